// File: verilog/imuldiv_pkg.sv
/*
 * shared types for the iterative multiply/divide unit
 * opcodes, request and response structs, FSM state types
 */
package imuldiv_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------

  // default operand width, the struct fields below are sized by it
  parameter int DATA_W_DEF = 32;

  // ------------------------------------------------------------
  // opcodes
  // ------------------------------------------------------------

  // bit 1 picks divide, bit 0 picks unsigned
  typedef enum logic [1:0] {
    OP_MUL  = 2'b00,
    OP_MULU = 2'b01,
    OP_DIV  = 2'b10,
    OP_DIVU = 2'b11
  } imuldiv_op_e;

  // ------------------------------------------------------------
  // request / response payloads
  // ------------------------------------------------------------

  // 66 bits at the default width
  typedef struct packed {
    imuldiv_op_e           op;
    logic [DATA_W_DEF-1:0] a;
    logic [DATA_W_DEF-1:0] b;
  } imuldiv_req_t;

  // divide result is {remainder, quotient}
  typedef struct packed {
    imuldiv_op_e             op;
    logic [2*DATA_W_DEF-1:0] result;
  } imuldiv_resp_t;

  // ------------------------------------------------------------
  // FSM states
  // ------------------------------------------------------------

  // load, iterate, sign fix-up, hold result
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    FIX  = 2'd2,
    DONE = 2'd3
  } mul_state_e;

  // divider walks through the same four states
  typedef mul_state_e div_state_e;

endpackage

// File: verilog/int_mul_dpath.sv
/*
 * multiplier datapath
 * shift-add over operand magnitudes, final conditional negate
 */
`timescale 1ns/10ps

module int_mul_dpath #(
  parameter int DATA_W = imuldiv_pkg::DATA_W_DEF
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [DATA_W-1:0]   a,
  input  logic [DATA_W-1:0]   b,
  input  logic                is_unsigned,
  input  logic                a_en,
  input  logic                b_en,
  input  logic                a_sel,
  input  logic                b_sel,
  input  logic                result_sel,
  input  logic                add_en,
  input  logic                fix_en,
  input  logic                neg,
  output logic [2*DATA_W-1:0] result,
  output logic                counter_is_zero,
  output logic                b_lsb,
  output logic                sign_diff
);

  localparam int CNT_W = $clog2(DATA_W);

  logic [2*DATA_W-1:0] a_reg;
  logic [DATA_W-1:0]   b_reg;
  logic [2*DATA_W-1:0] acc;
  logic [CNT_W-1:0]    counter;
  logic                sign_diff_q;

  logic [DATA_W-1:0]   a_mag;
  logic [DATA_W-1:0]   b_mag;
  logic [2*DATA_W-1:0] a_next;
  logic [DATA_W-1:0]   b_next;
  logic [2*DATA_W-1:0] acc_calc;
  logic [2*DATA_W-1:0] acc_next;
  logic                load;

  // ------------------------------------------------------------
  // operand front end
  // ------------------------------------------------------------

  // load cycle is the one enable with the init select
  assign load = a_en && !a_sel;

  // magnitudes, unsigned ops pass straight through
  assign a_mag = (!is_unsigned && a[DATA_W-1]) ? (~a + 1'b1) : a;
  assign b_mag = (!is_unsigned && b[DATA_W-1]) ? (~b + 1'b1) : b;

  // a grows left into the upper half, b drains right
  assign a_next = a_sel ? {a_reg[2*DATA_W-2:0], 1'b0} : {{DATA_W{1'b0}}, a_mag};
  assign b_next = b_sel ? {1'b0, b_reg[DATA_W-1:1]} : b_mag;

  // ------------------------------------------------------------
  // accumulator
  // ------------------------------------------------------------

  // add_en comes from the controller, already qualified by b lsb
  assign acc_calc = add_en ? (acc + a_reg) : acc;

  always_comb begin
    if (fix_en) begin
      acc_next = neg ? (~acc + 1'b1) : acc;
    end else begin
      // result_sel low clears for a new operation
      acc_next = result_sel ? acc_calc : '0;
    end
  end

  // operand and result registers
  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
    if (b_en) begin
      b_reg <= b_next;
    end
    if (a_en || fix_en) begin
      acc <= acc_next;
    end
    if (load) begin
      // signed only, product negative when exactly one operand is
      sign_diff_q <= !is_unsigned && (a[DATA_W-1] ^ b[DATA_W-1]);
    end
  end

  // iteration counter, W-1 down to 0
  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= '0;
    end else if (load) begin
      counter <= CNT_W'(DATA_W - 1);
    end else if (a_en) begin
      counter <= counter - 1'b1;
    end
  end

  // status back to the controller
  assign counter_is_zero = (counter == '0);
  assign b_lsb           = b_reg[0];
  assign sign_diff       = sign_diff_q;
  assign result          = acc;

endmodule

// File: verilog/int_mul_ctrl.sv
/*
 * multiplier controller
 * FSM for load, shift-add iterations, fix-up and response hold
 */
`timescale 1ns/10ps

module int_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_valid,
  input  logic resp_ready,
  input  logic counter_is_zero,
  input  logic b_lsb,
  input  logic sign_diff,
  output logic req_ready,
  output logic resp_valid,
  output logic a_en,
  output logic b_en,
  output logic a_sel,
  output logic b_sel,
  output logic result_sel,
  output logic add_en,
  output logic fix_en,
  output logic neg
);

  import imuldiv_pkg::*;

  mul_state_e state;
  mul_state_e state_next;

  // ------------------------------------------------------------
  // state register and transitions
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req_valid) begin
          state_next = CALC;
        end
      end
      // last iteration runs with the counter at zero
      CALC: begin
        if (counter_is_zero) begin
          state_next = FIX;
        end
      end
      FIX: state_next = DONE;
      // hold the product until the consumer takes it
      DONE: begin
        if (resp_ready) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  // ------------------------------------------------------------
  // datapath control
  // ------------------------------------------------------------

  always_comb begin
    req_ready  = 1'b0;
    resp_valid = 1'b0;
    a_en       = 1'b0;
    b_en       = 1'b0;
    a_sel      = 1'b0;
    b_sel      = 1'b0;
    result_sel = 1'b0;
    add_en     = 1'b0;
    fix_en     = 1'b0;
    neg        = 1'b0;
    case (state)
      IDLE: begin
        // load magnitudes and clear accumulator on accept
        req_ready = 1'b1;
        a_en      = req_valid;
        b_en      = req_valid;
      end
      CALC: begin
        a_en       = 1'b1;
        b_en       = 1'b1;
        a_sel      = 1'b1;
        b_sel      = 1'b1;
        result_sel = 1'b1;
        // partial product only when the current b bit is set
        add_en     = b_lsb;
      end
      FIX: begin
        fix_en = 1'b1;
        neg    = sign_diff;
      end
      DONE: resp_valid = 1'b1;
      default: ;
    endcase
  end

endmodule

// File: verilog/int_mul_iterative.sv
/*
 * iterative multiplier, controller plus datapath on struct ports
 */
`timescale 1ns/10ps

module int_mul_iterative #(
  parameter int DATA_W = imuldiv_pkg::DATA_W_DEF
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_valid,
  output logic                       req_ready,
  input  imuldiv_pkg::imuldiv_req_t  req,
  output logic                       resp_valid,
  input  logic                       resp_ready,
  output imuldiv_pkg::imuldiv_resp_t resp
);

  import imuldiv_pkg::*;

  logic                a_en;
  logic                b_en;
  logic                a_sel;
  logic                b_sel;
  logic                result_sel;
  logic                add_en;
  logic                fix_en;
  logic                neg;
  logic                counter_is_zero;
  logic                b_lsb;
  logic                sign_diff;
  logic [2*DATA_W-1:0] result;
  imuldiv_op_e         op_q;

  // opcode rides along with the operation
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      op_q <= req.op;
    end
  end

  int_mul_ctrl u_ctrl (
    .clk             (clk),
    .reset           (reset),
    .req_valid       (req_valid),
    .resp_ready      (resp_ready),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb),
    .sign_diff       (sign_diff),
    .req_ready       (req_ready),
    .resp_valid      (resp_valid),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_sel           (a_sel),
    .b_sel           (b_sel),
    .result_sel      (result_sel),
    .add_en          (add_en),
    .fix_en          (fix_en),
    .neg             (neg)
  );

  // bit 0 of the opcode marks the unsigned form
  int_mul_dpath #(
    .DATA_W (DATA_W)
  ) u_dpath (
    .clk             (clk),
    .reset           (reset),
    .a               (req.a),
    .b               (req.b),
    .is_unsigned     (req.op[0]),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_sel           (a_sel),
    .b_sel           (b_sel),
    .result_sel      (result_sel),
    .add_en          (add_en),
    .fix_en          (fix_en),
    .neg             (neg),
    .result          (result),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb),
    .sign_diff       (sign_diff)
  );

  assign resp = '{op: op_q, result: result};

endmodule

// File: verilog/int_div_iterative.sv
/*
 * iterative restoring divider
 * magnitude shift-subtract, result is {remainder, quotient}
 */
`timescale 1ns/10ps

module int_div_iterative #(
  parameter int DATA_W = imuldiv_pkg::DATA_W_DEF
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_valid,
  output logic                       req_ready,
  input  imuldiv_pkg::imuldiv_req_t  req,
  output logic                       resp_valid,
  input  logic                       resp_ready,
  output imuldiv_pkg::imuldiv_resp_t resp
);

  import imuldiv_pkg::*;

  localparam int CNT_W = $clog2(DATA_W);

  div_state_e       state;
  div_state_e       state_next;
  logic [CNT_W-1:0] count;

  imuldiv_op_e      op_q;
  logic [DATA_W-1:0] rem_q;
  logic [DATA_W-1:0] quo_q;
  logic [DATA_W-1:0] dvs_q;
  logic              neg_quo;
  logic              neg_rem;

  logic              accept;
  logic              a_neg;
  logic              b_neg;
  logic [DATA_W-1:0] a_mag;
  logic [DATA_W-1:0] b_mag;
  logic [DATA_W:0]   shifted;
  logic [DATA_W:0]   diff;

  // ------------------------------------------------------------
  // operand front end
  // ------------------------------------------------------------

  assign accept = req_valid && req_ready;

  // sign bits only count for the signed opcode
  assign a_neg = !req.op[0] && req.a[DATA_W-1];
  assign b_neg = !req.op[0] && req.b[DATA_W-1];
  assign a_mag = a_neg ? (~req.a + 1'b1) : req.a;
  assign b_mag = b_neg ? (~req.b + 1'b1) : req.b;

  // next dividend bit enters the partial remainder
  assign shifted = {rem_q, quo_q[DATA_W-1]};
  // trial subtract, top bit set means the divisor did not fit
  assign diff = shifted - {1'b0, dvs_q};

  // ------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      if (accept) begin
        count <= CNT_W'(DATA_W - 1);
      end else if (state == CALC) begin
        count <= count - 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req_valid) begin
          state_next = CALC;
        end
      end
      CALC: begin
        if (count == '0) begin
          state_next = FIX;
        end
      end
      FIX: state_next = DONE;
      DONE: begin
        if (resp_ready) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  assign req_ready  = (state == IDLE);
  assign resp_valid = (state == DONE);

  // ------------------------------------------------------------
  // remainder / quotient registers
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q  <= req.op;
      rem_q <= '0;
      // quotient register starts out holding the dividend
      quo_q <= a_mag;
      dvs_q <= b_mag;
      // zero divisor keeps the all-ones quotient unsigned
      neg_quo <= (a_neg ^ b_neg) && (req.b != '0);
      // remainder follows the dividend sign
      neg_rem <= a_neg;
    end else if (state == CALC) begin
      if (!diff[DATA_W]) begin
        rem_q <= diff[DATA_W-1:0];
        quo_q <= {quo_q[DATA_W-2:0], 1'b1};
      end else begin
        // restore, keep the shifted remainder
        rem_q <= shifted[DATA_W-1:0];
        quo_q <= {quo_q[DATA_W-2:0], 1'b0};
      end
    end else if (state == FIX) begin
      if (neg_quo) begin
        quo_q <= ~quo_q + 1'b1;
      end
      if (neg_rem) begin
        rem_q <= ~rem_q + 1'b1;
      end
    end
  end

  assign resp = '{op: op_q, result: {rem_q, quo_q}};

endmodule

// File: verilog/imuldiv_top.sv
/*
 * multiply/divide unit top, opcode dispatch and
 * fixed-priority response merge with the multiplier first
 */
`timescale 1ns/10ps

module imuldiv_top #(
  parameter int DATA_W = imuldiv_pkg::DATA_W_DEF
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_valid,
  output logic                       req_ready,
  input  imuldiv_pkg::imuldiv_req_t  req,
  output logic                       resp_valid,
  input  logic                       resp_ready,
  output imuldiv_pkg::imuldiv_resp_t resp
);

  import imuldiv_pkg::*;

  logic          is_div;
  logic          mul_req_valid;
  logic          mul_req_ready;
  logic          div_req_valid;
  logic          div_req_ready;
  logic          mul_resp_valid;
  logic          mul_resp_ready;
  logic          div_resp_valid;
  logic          div_resp_ready;
  imuldiv_resp_t mul_resp;
  imuldiv_resp_t div_resp;

  // ------------------------------------------------------------
  // request dispatch
  // ------------------------------------------------------------

  // opcode bit 1 picks the divider
  assign is_div        = req.op[1];
  assign mul_req_valid = req_valid && !is_div;
  assign div_req_valid = req_valid && is_div;
  assign req_ready     = is_div ? div_req_ready : mul_req_ready;

  int_mul_iterative #(
    .DATA_W (DATA_W)
  ) u_mul (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (mul_req_valid),
    .req_ready  (mul_req_ready),
    .req        (req),
    .resp_valid (mul_resp_valid),
    .resp_ready (mul_resp_ready),
    .resp       (mul_resp)
  );

  int_div_iterative #(
    .DATA_W (DATA_W)
  ) u_div (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (div_req_valid),
    .req_ready  (div_req_ready),
    .req        (req),
    .resp_valid (div_resp_valid),
    .resp_ready (div_resp_ready),
    .resp       (div_resp)
  );

  // ------------------------------------------------------------
  // response merge
  // ------------------------------------------------------------

  // multiplier wins, divider waits in DONE until the port frees up
  assign resp_valid     = mul_resp_valid || div_resp_valid;
  assign resp           = mul_resp_valid ? mul_resp : div_resp;
  assign mul_resp_ready = resp_ready;
  assign div_resp_ready = resp_ready && !mul_resp_valid;

endmodule

// File: testbench/imuldiv_properties.sv
/*
 * protocol checks for the multiply/divide top, bound into imuldiv_top
 */
`timescale 1ns/10ps

module imuldiv_properties (
  input logic                       clk,
  input logic                       reset,
  input logic                       req_valid,
  input logic                       req_ready,
  input imuldiv_pkg::imuldiv_req_t  req,
  input logic                       resp_valid,
  input logic                       resp_ready,
  input imuldiv_pkg::imuldiv_resp_t resp,
  input logic                       mul_req_valid,
  input logic                       mul_req_ready,
  input logic                       div_req_valid,
  input logic                       div_req_ready,
  input logic                       mul_resp_valid,
  input logic                       mul_resp_ready,
  input logic                       div_resp_valid,
  input logic                       div_resp_ready,
  input imuldiv_pkg::imuldiv_resp_t mul_resp,
  input imuldiv_pkg::imuldiv_resp_t div_resp
);

  import imuldiv_pkg::*;

  int unsigned fail_count = 0;
  logic        mul_busy;
  logic        div_busy;

  // a unit is busy from accept until its response handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      mul_busy <= 1'b0;
      div_busy <= 1'b0;
    end else begin
      if (mul_req_valid && mul_req_ready) begin
        mul_busy <= 1'b1;
      end else if (mul_resp_valid && mul_resp_ready) begin
        mul_busy <= 1'b0;
      end
      if (div_req_valid && div_req_ready) begin
        div_busy <= 1'b1;
      end else if (div_resp_valid && div_resp_ready) begin
        div_busy <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // properties
  // ------------------------------------------------------------

  // idle and empty right after reset
  idle_after_reset: assert property (@(posedge clk)
    reset |=> (!resp_valid && req_ready))
  else begin
    $error("response valid or request not ready after reset");
    fail_count++;
  end

  // each unit holds its response steady until taken
  mul_hold: assert property (@(posedge clk) disable iff (reset)
    (mul_resp_valid && !mul_resp_ready) |=> (mul_resp_valid && $stable(mul_resp)))
  else begin
    $error("multiplier response changed under back-pressure");
    fail_count++;
  end

  div_hold: assert property (@(posedge clk) disable iff (reset)
    (div_resp_valid && !div_resp_ready) |=> (div_resp_valid && $stable(div_resp)))
  else begin
    $error("divider response changed under back-pressure");
    fail_count++;
  end

  // merged port keeps its response unless the multiplier takes it over
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && !resp_ready) |=>
      (resp_valid && ($stable(resp) || $rose(mul_resp_valid))))
  else begin
    $error("merged response changed under back-pressure");
    fail_count++;
  end

  // no second request into a unit that still holds one
  no_accept_busy: assert property (@(posedge clk) disable iff (reset)
    (req_valid && ((req.op[1] && div_busy) || (!req.op[1] && mul_busy))) |-> !req_ready)
  else begin
    $error("request ready while the selected unit is busy");
    fail_count++;
  end

endmodule

bind imuldiv_top imuldiv_properties u_props (
  .clk            (clk),
  .reset          (reset),
  .req_valid      (req_valid),
  .req_ready      (req_ready),
  .req            (req),
  .resp_valid     (resp_valid),
  .resp_ready     (resp_ready),
  .resp           (resp),
  .mul_req_valid  (mul_req_valid),
  .mul_req_ready  (mul_req_ready),
  .div_req_valid  (div_req_valid),
  .div_req_ready  (div_req_ready),
  .mul_resp_valid (mul_resp_valid),
  .mul_resp_ready (mul_resp_ready),
  .div_resp_valid (div_resp_valid),
  .div_resp_ready (div_resp_ready),
  .mul_resp       (mul_resp),
  .div_resp       (div_resp)
);

// File: testbench/imuldiv_tb.sv
/*
 * testbench for the multiply/divide unit
 * directed and random requests against per-unit reference queues
 */
`timescale 1ns/10ps

module imuldiv_tb;

  import imuldiv_pkg::*;

  localparam int W          = 32;
  localparam int WAIT_LIMIT = 200;
  localparam int DRAIN_LIMIT = 600;

  logic          clk;
  logic          reset;
  logic          req_valid;
  logic          req_ready;
  imuldiv_req_t  req;
  logic          resp_valid;
  logic          resp_ready;
  imuldiv_resp_t resp;

  // reference queues, one per unit, fronts and counts seen by the assertions
  imuldiv_resp_t mul_q[$];
  imuldiv_resp_t div_q[$];
  imuldiv_resp_t mul_front;
  imuldiv_resp_t div_front;
  int            mul_pending;
  int            div_pending;

  int            errors;
  int            tests;
  int            requests;
  int            responses;
  int            test_start_errors;
  logic          timed_out;
  integer        seed;
  int            bp_mode;
  int            hold_left;
  logic [W-1:0]  corners [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

  imuldiv_top #(
    .DATA_W (W)
  ) u_dut (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  // full product, or {remainder, quotient} with truncating division
  function automatic imuldiv_resp_t expected_resp(input imuldiv_req_t r);
    longint          sa;
    longint          sb;
    longint unsigned ua;
    longint unsigned ub;
    logic [W-1:0]    quo;
    logic [W-1:0]    rem;
    imuldiv_resp_t   e;
    sa = longint'($signed(r.a));
    sb = longint'($signed(r.b));
    ua = {{W{1'b0}}, r.a};
    ub = {{W{1'b0}}, r.b};
    e.op = r.op;
    if (r.b == '0) begin
      // divide by zero, all ones quotient and dividend as remainder
      quo = '1;
      rem = r.a;
    end else if (r.op == OP_DIV) begin
      quo = W'(sa / sb);
      rem = W'(sa % sb);
    end else begin
      quo = W'(ua / ub);
      rem = W'(ua % ub);
    end
    case (r.op)
      OP_MUL:  e.result = sa * sb;
      OP_MULU: e.result = ua * ub;
      default: e.result = {rem, quo};
    endcase
    return e;
  endfunction

  // push on accept, pop on response, both sampled at the clock edge
  always @(posedge clk) begin
    if (reset) begin
      mul_q.delete();
      div_q.delete();
    end else begin
      if (resp_valid && resp_ready) begin
        responses++;
        if (resp.op[1] && div_q.size() > 0) begin
          void'(div_q.pop_front());
        end else if (!resp.op[1] && mul_q.size() > 0) begin
          void'(mul_q.pop_front());
        end
      end
      if (req_valid && req_ready) begin
        requests++;
        if (req.op[1]) begin
          div_q.push_back(expected_resp(req));
        end else begin
          mul_q.push_back(expected_resp(req));
        end
      end
    end
    mul_front   <= (mul_q.size() > 0) ? mul_q[0] : '0;
    div_front   <= (div_q.size() > 0) ? div_q[0] : '0;
    mul_pending <= mul_q.size();
    div_pending <= div_q.size();
  end

  // response must equal the oldest outstanding entry of its unit
  check_resp: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && resp_ready) |-> (resp == (resp.op[1] ? div_front : mul_front)))
  else begin
    $display("ERR resp.result expected %h received %h (op %0d)",
             $sampled(resp.op[1]) ? $sampled(div_front.result) : $sampled(mul_front.result),
             $sampled(resp.result), $sampled(resp.op));
    errors++;
  end

  // a response with nothing outstanding is a duplicate
  check_outstanding: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && resp_ready) |-> ((resp.op[1] ? div_pending : mul_pending) != 0))
  else begin
    $display("response arrived with no request outstanding for its unit");
    errors++;
  end

  // ------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------

  // 0 always ready, 1 random hold periods, 2 held low
  always @(posedge clk) begin
    if (bp_mode == 0) begin
      resp_ready <= 1'b1;
    end else if (bp_mode == 2) begin
      resp_ready <= 1'b0;
    end else if (hold_left == 0) begin
      resp_ready <= ~resp_ready;
      hold_left = $random(seed) & 7;
    end else begin
      hold_left--;
    end
  end

  function automatic int total_errors();
    return errors + u_dut.u_props.fail_count;
  endfunction

  task automatic send_req(input imuldiv_op_e op, input logic [W-1:0] a,
                          input logic [W-1:0] b);
    int n;
    if (timed_out) return;
    n = 0;
    req_valid <= 1'b1;
    req       <= '{op: op, a: a, b: b};
    @(posedge clk);
    while (!req_ready && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    req_valid <= 1'b0;
    if (!req_ready) begin
      $display("request was not accepted within %0d cycles", WAIT_LIMIT);
      timed_out = 1'b1;
      errors++;
    end
  endtask

  // pending counts lag the edge by one, so start one cycle later
  task automatic drain_responses();
    int n;
    if (timed_out) return;
    n = 0;
    @(posedge clk);
    while ((mul_pending + div_pending) != 0 && n < DRAIN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if ((mul_pending + div_pending) != 0) begin
      $display("responses still outstanding after %0d cycles", DRAIN_LIMIT);
      timed_out = 1'b1;
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s finished, %0d new errors", name, total_errors() - test_start_errors);
    test_start_errors = total_errors();
  endtask

  task automatic send_random(input int count);
    integer rnd;
    for (int i = 0; i < count; i++) begin
      rnd = $random(seed);
      send_req(imuldiv_op_e'(rnd[1:0]), $random(seed), $random(seed));
    end
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial begin
    seed              = 32'h9f671de1;
    reset             = 1'b1;
    req_valid         = 1'b0;
    req               = '0;
    resp_ready        = 1'b0;
    bp_mode           = 0;
    hold_left         = 0;
    errors            = 0;
    tests             = 0;
    requests          = 0;
    responses         = 0;
    test_start_errors = 0;
    timed_out         = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    foreach (corners[i]) begin
      foreach (corners[j]) begin
        send_req(OP_MUL, corners[i], corners[j]);
        send_req(OP_MULU, corners[i], corners[j]);
      end
    end
    drain_responses();
    end_test("mul_corners");

    // zero divisor sits in the corner set
    foreach (corners[i]) begin
      foreach (corners[j]) begin
        send_req(OP_DIV, corners[i], corners[j]);
        send_req(OP_DIVU, corners[i], corners[j]);
      end
    end
    drain_responses();
    end_test("div_corners");

    // both units finish while the port is held, merge must pick the multiply
    bp_mode <= 2;
    send_req(OP_MUL, 32'hffff_fff9, 32'h0000_1234);
    send_req(OP_DIV, 32'h8000_0001, 32'h0000_0013);
    repeat (40) @(posedge clk);
    check_mul_first: assert (resp_valid && resp.op == OP_MUL)
    else begin
      $display("ERR resp.op expected %h received %h", OP_MUL, resp.op);
      errors++;
    end
    bp_mode <= 0;
    drain_responses();
    send_req(OP_DIVU, 32'hdead_beef, 32'h0000_0100);
    send_req(OP_MULU, 32'hcafe_f00d, 32'h1234_5678);
    drain_responses();
    end_test("mul_div_overlap");

    bp_mode <= 1;
    send_random(30);
    drain_responses();
    end_test("backpressure");

    send_random(200);
    drain_responses();
    bp_mode <= 0;
    end_test("random");

    $display("tests %0d, requests %0d, responses %0d, errors %0d",
             tests, requests, responses, total_errors());
    if (total_errors() == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: imuldiv_top.f
verilog/imuldiv_pkg.sv
verilog/int_mul_dpath.sv
verilog/int_mul_ctrl.sv
verilog/int_mul_iterative.sv
verilog/int_div_iterative.sv
verilog/imuldiv_top.sv
testbench/imuldiv_properties.sv
testbench/imuldiv_tb.sv

// File: Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := imuldiv_tb
FILELIST  := imuldiv_top.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+1000
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) $(RUN_FLAGS) 2>&1 | tee $(LOG)

check: run
	@grep -q "All checks passed" $(LOG) && echo "simulation PASS" || \
		(echo "simulation FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
